/* hdl/board_top.sv */
/*
 * board top, peripheral side of the SoC
 * reset stretcher, bus decoder, GPIO with LED scroller, timer
 */
`timescale 1ns/1ns

module board_top (
	input  logic        clk,
	input  logic        resetn,
	input  logic        mem_valid,
	input  logic [3:0]  mem_wstrb,
	input  logic [31:0] mem_addr,
	input  logic [31:0] mem_wdata,
	output logic        mem_ready,
	output logic [31:0] mem_rdata,
	output logic [7:0]  leds,
	output logic        timer_irq
);

	logic        sys_resetn;
	logic        gpio_sel;
	logic        gpio_ready;
	logic [31:0] gpio_rdata;
	logic [31:0] gpio;
	logic        timer_sel;
	logic        timer_ready;
	logic [31:0] timer_rdata;

	// ********************
	// reset
	// ********************
	por_stretch u_por (
		.clk        (clk),
		.resetn     (resetn),
		.sys_resetn (sys_resetn)
	);

	// ********************
	// bus decode
	// ********************
	iomem_decode u_decode (
		.clk         (clk),
		.resetn      (sys_resetn),
		.mem_valid   (mem_valid),
		.mem_addr    (mem_addr),
		.mem_ready   (mem_ready),
		.mem_rdata   (mem_rdata),
		.gpio_sel    (gpio_sel),
		.gpio_ready  (gpio_ready),
		.gpio_rdata  (gpio_rdata),
		.timer_sel   (timer_sel),
		.timer_ready (timer_ready),
		.timer_rdata (timer_rdata)
	);

	// ********************
	// peripherals
	// ********************
	gpio_reg u_gpio (
		.clk    (clk),
		.resetn (sys_resetn),
		.sel    (gpio_sel),
		.wstrb  (mem_wstrb),
		.wdata  (mem_wdata),
		.ready  (gpio_ready),
		.rdata  (gpio_rdata),
		.gpio   (gpio)
	);

	led_scroller u_leds (
		.clk    (clk),
		.resetn (sys_resetn),
		.gpio   (gpio),
		.leds   (leds)
	);

	// address bit 2 picks count or ctrl
	iomem_timer u_timer (
		.clk      (clk),
		.resetn   (sys_resetn),
		.sel      (timer_sel),
		.addr_reg (mem_addr[2]),
		.wstrb    (mem_wstrb),
		.wdata    (mem_wdata),
		.ready    (timer_ready),
		.rdata    (timer_rdata),
		.irq      (timer_irq)
	);

endmodule

/* hdl/gpio_reg.sv */
/*
 * 32-bit GPIO register on the peripheral bus, byte-writable
 */
`timescale 1ns/1ns

module gpio_reg (
	input  logic        clk,
	input  logic        resetn,
	input  logic        sel,
	input  logic [3:0]  wstrb,
	input  logic [31:0] wdata,
	output logic        ready,
	output logic [31:0] rdata,
	output logic [31:0] gpio
);

	// ********************
	// register and ready
	// ********************
	always_ff @(posedge clk) begin
		if (!resetn) begin
			gpio  <= '0;
			ready <= 1'b0;
		end else begin
			// one-cycle pulse per strobe
			ready <= sel;
			if (sel) begin
				// merge only the strobed bytes
				for (int b = 0; b < 4; b++) begin
					if (wstrb[b])
						gpio[b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
		end
	end

	// ********************
	// read data
	// ********************
	// old value, before this access's write
	always_ff @(posedge clk) begin
		if (sel)
			rdata <= gpio;
	end

endmodule

/* hdl/iomem_decode.sv */
/*
 * address decoder for the peripheral bus
 * per-slave select strobes, ready merge, read mux, unmapped response
 */
`timescale 1ns/1ns

module iomem_decode import iomem_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        mem_valid,
	input  logic [31:0] mem_addr,
	output logic        mem_ready,
	output logic [31:0] mem_rdata,
	output logic        gpio_sel,
	input  logic        gpio_ready,
	input  logic [31:0] gpio_rdata,
	output logic        timer_sel,
	input  logic        timer_ready,
	input  logic [31:0] timer_rdata
);

	logic        hit_gpio;
	logic        hit_timer;
	logic        req_new;
	logic        unmapped_ready;
	periph_sel_t sel_q;

	// ********************
	// region decode
	// ********************
	assign hit_gpio  = (mem_addr[31:24] == periph_gpio);
	assign hit_timer = (mem_addr[31:24] == periph_timer);

	// request not yet answered
	// ready high means this access is done, block a second strobe
	assign req_new = mem_valid && !mem_ready;

	assign gpio_sel  = req_new && hit_gpio;
	assign timer_sel = req_new && hit_timer;

	// ********************
	// target tracking and unmapped answer
	// ********************
	always_ff @(posedge clk) begin
		if (!resetn) begin
			sel_q          <= sel_none;
			unmapped_ready <= 1'b0;
		end else begin
			unmapped_ready <= req_new && !hit_gpio && !hit_timer;
			if (req_new) begin
				if (hit_gpio)
					sel_q <= sel_gpio;
				else if (hit_timer)
					sel_q <= sel_timer;
				else
					sel_q <= sel_none;
			end
		end
	end

	// ready and read data back to the master
	assign mem_ready = gpio_ready | timer_ready | unmapped_ready;

	always_comb begin
		case (sel_q)
			sel_gpio:  mem_rdata = gpio_rdata;
			sel_timer: mem_rdata = timer_rdata;
			// unmapped reads return zero
			default:   mem_rdata = '0;
		endcase
	end

	// ********************
	// checks
	// ********************
	// one responder per access
	assert property (@(posedge clk) disable iff (!resetn)
		$onehot0({gpio_ready, timer_ready, unmapped_ready}));

	// no ready without a request on the edge before
	assert property (@(posedge clk) disable iff (!resetn)
		mem_ready |-> $past(mem_valid));

endmodule

/* hdl/iomem_pkg.sv */
/*
 * shared definitions for the peripheral bus of the board top
 * address map, limits and enumerated types
 */
package iomem_pkg;

	// ********************
	// address map, bits 31:24 of mem_addr
	// ********************
	localparam logic [7:0] periph_gpio  = 8'h03;
	localparam logic [7:0] periph_timer = 8'h04;

	// ********************
	// limits
	// ********************
	// scroll stops at this shift
	localparam integer led_shift_max = 10;
	// reset stretch length in clock cycles
	localparam logic [5:0] por_cycles = 6'd63;

	// ********************
	// types
	// ********************
	// registered target of the current access
	typedef enum logic [1:0] {
		sel_none,
		sel_gpio,
		sel_timer
	} periph_sel_t;

	// timer register, picked by address bit 2
	typedef enum logic {
		treg_count,
		treg_ctrl
	} timer_reg_t;

endpackage

/* hdl/iomem_timer.sv */
/*
 * down-counting timer on the peripheral bus
 * count and ctrl registers, pending flag drives the interrupt
 */
`timescale 1ns/1ns

module iomem_timer import iomem_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        sel,
	input  logic        addr_reg,
	input  logic [3:0]  wstrb,
	input  logic [31:0] wdata,
	output logic        ready,
	output logic [31:0] rdata,
	output logic        irq
);

	logic [31:0] count;
	logic [31:0] count_merged;
	logic        enable;
	logic        pending;
	logic        wr_count;
	logic        wr_ctrl;
	logic        running;
	logic        expire;
	timer_reg_t  reg_sel;

	assign reg_sel  = timer_reg_t'(addr_reg);
	assign wr_count = sel && |wstrb && reg_sel == treg_count;
	assign wr_ctrl  = sel && |wstrb && reg_sel == treg_ctrl;

	// count with the strobed bytes replaced
	always_comb begin
		count_merged = count;
		for (int b = 0; b < 4; b++) begin
			if (wstrb[b])
				count_merged[b*8 +: 8] = wdata[b*8 +: 8];
		end
	end

	// ********************
	// counter
	// ********************
	assign running = enable && count != '0;
	// last step, 1 to 0
	assign expire  = running && !wr_count && count == 32'd1;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			count   <= '0;
			enable  <= 1'b0;
			pending <= 1'b0;
			ready   <= 1'b0;
		end else begin
			ready <= sel;
			// bus load wins over the decrement
			if (wr_count)
				count <= count_merged;
			else if (running)
				count <= count - 32'd1;

			if (wr_ctrl && wstrb[0])
				enable <= wdata[0];

			// a new expiry is not lost to a clear in the same cycle
			if (expire)
				pending <= 1'b1;
			else if (wr_ctrl && wstrb[0] && wdata[1])
				pending <= 1'b0;
		end
	end

	assign irq = pending;

	// read data, value before this access's write
	always_ff @(posedge clk) begin
		if (sel)
			rdata <= (reg_sel == treg_count) ? count : {30'b0, pending, enable};
	end

	// zero only leaves by a bus load
	assert property (@(posedge clk) disable iff (!resetn)
		(count == '0 && !wr_count) |=> count == '0);

endmodule

/* hdl/led_scroller.sv */
/*
 * LED view of the GPIO low byte, scrolls right while all LEDs are lit
 */
`timescale 1ns/1ns

module led_scroller import iomem_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic [31:0] gpio,
	output logic [7:0]  leds
);

	// shift amount, only reset clears it
	logic [4:0] shift;
	logic       all_lit;

	assign leds    = gpio[7:0] >> shift;
	assign all_lit = &leds;

	// one step per cycle, up to the limit
	always_ff @(posedge clk) begin
		if (!resetn) begin
			shift <= '0;
		end else if (all_lit && shift < 5'(led_shift_max)) begin
			shift <= shift + 5'd1;
		end
	end

	// shift stays within the cap
	assert property (@(posedge clk) disable iff (!resetn)
		shift <= 5'(led_shift_max));

endmodule

/* hdl/por_stretch.sv */
/*
 * reset stretcher, holds the fabric in reset for a fixed count
 * after the external reset is released
 */
`timescale 1ns/1ns

module por_stretch import iomem_pkg::*; (
	input  logic clk,
	input  logic resetn,
	output logic sys_resetn
);

	// stretch counter, saturates at por_cycles
	logic [5:0] cnt;
	logic       cnt_done;

	assign cnt_done = (cnt == por_cycles);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			// any low resetn restarts the stretch
			cnt        <= '0;
			sys_resetn <= 1'b0;
		end else begin
			if (!cnt_done) begin
				cnt <= cnt + 6'd1;
			end
			// released one edge after the terminal count
			sys_resetn <= cnt_done;
		end
	end

endmodule

/* verification/tb_board_top.sv */
/*
 * testbench for the board top peripheral bus
 * bus master tasks, GPIO, LED scroll and timer shadow models
 */
`timescale 1ns/1ns

module tb_board_top import iomem_pkg::*; ();

	logic        clk;
	logic        resetn;
	logic        mem_valid;
	logic [3:0]  mem_wstrb;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic        mem_ready;
	logic [31:0] mem_rdata;
	logic [7:0]  leds;
	logic        timer_irq;

	logic [31:0] gpio_addr  = {periph_gpio, 24'h0};
	logic [31:0] count_addr = {periph_timer, 21'h0, treg_count, 2'b00};
	logic [31:0] ctrl_addr  = {periph_timer, 21'h0, treg_ctrl, 2'b00};

	// shadow state and bookkeeping
	logic [31:0] gpio_m = '0;
	logic [4:0]  shift_m = '0;
	logic [31:0] rng = 32'd13;
	logic        irq_clear_req = 1'b0;
	logic        stretch_done;
	int          edges = 0;
	int          ready_edge = 0;
	int          errors = 0;
	int          tests = 0;
	int          test_start = 0;

	board_top board_top_inst (.*);

	always #50 clk = ~clk;

	// edges since resetn was sampled high, models the stretch
	always @(posedge clk) begin
		if (!resetn)
			edges <= 0;
		else if (edges < 1000)
			edges <= edges + 1;
	end
	assign stretch_done = edges > por_cycles;

	// ********************
	// protocol checks
	// ********************
	assert property (@(posedge clk) (mem_valid && !mem_ready && stretch_done) |=> mem_ready)
		else note_error("no mem_ready one cycle after a request");
	assert property (@(posedge clk) mem_ready |=> !mem_ready)
		else note_error("mem_ready held for more than one cycle");
	assert property (@(posedge clk) (edges != 0 && !stretch_done) |->
		(!mem_ready && !timer_irq && leds == 8'h00))
		else note_error("outputs left their reset values during the stretch");
	assert property (@(posedge clk) (timer_irq && !irq_clear_req) |=> timer_irq)
		else note_error("timer_irq dropped without a pending clear");

	// ********************
	// helpers
	// ********************
	function automatic logic [31:0] next_random(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// byte-wise write merge
	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
		input logic [31:0] data, input logic [3:0] strb);
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				old[b*8 +: 8] = data[b*8 +: 8];
		end
		return old;
	endfunction

	// shift where the scroll stops for this low byte
	function automatic logic [4:0] settled_shift(input logic [7:0] lo, input logic [4:0] s);
		while (s < led_shift_max && (lo >> s) == 8'hff)
			s++;
		return s;
	endfunction

	task automatic note_error(input string msg);
		errors++;
		$display("%0t: %s", $time, msg);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %s = %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("[%0d] %s: %0d errors", tests, name, errors - test_start);
		test_start = errors;
	endtask

	// one bus access, ready sampled at the falling edge
	task automatic bus_xfer(input logic [31:0] addr, input logic [3:0] strb,
		input logic [31:0] data, input logic chk, input logic [31:0] exp,
		output logic [31:0] rd);
		int waited;
		waited = 0;
		@(posedge clk);
		mem_valid <= 1'b1;
		mem_addr  <= addr;
		mem_wstrb <= strb;
		mem_wdata <= data;
		do begin
			@(negedge clk);
			waited++;
		end while (!mem_ready && waited < 200);
		if (!mem_ready)
			note_error($sformatf("no mem_ready for access to %h", addr));
		rd = mem_rdata;
		ready_edge = edges;
		if (chk)
			check_value("mem_rdata", rd, exp);
		@(posedge clk);
		mem_valid <= 1'b0;
		mem_wstrb <= 4'h0;
	endtask

	task automatic gpio_write(input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] rd;
		// write returns the old value
		bus_xfer(gpio_addr, strb, data, 1'b1, gpio_m, rd);
		gpio_m = merge_bytes(gpio_m, data, strb);
		shift_m = settled_shift(gpio_m[7:0], shift_m);
	endtask

	// wait until leds hold for one cycle
	task automatic leds_settle();
		logic [7:0] prev;
		int         waited;
		waited = 0;
		@(negedge clk);
		do begin
			prev = leds;
			@(negedge clk);
			waited++;
		end while (leds != prev && waited < 2 * led_shift_max);
		if (leds != prev)
			note_error("leds kept changing past the settle timeout");
	endtask

	// ********************
	// test sequence
	// ********************
	initial begin
		logic [31:0] rd;
		logic [31:0] prev;
		logic [31:0] data;
		int          polls;

		clk       = 1'b0;
		resetn    = 1'b0;
		mem_valid = 1'b0;
		mem_wstrb = 4'h0;
		mem_addr  = '0;
		mem_wdata = '0;
		repeat (10) @(posedge clk);
		resetn <= 1'b1;

		// request goes out inside the stretch
		bus_xfer(gpio_addr, 4'h0, '0, 1'b1, '0, rd);
		assert (ready_edge > por_cycles + 1)
		else note_error("request answered before the reset stretch ended");
		@(negedge clk);
		check_value("leds", leds, 8'h00);
		check_value("timer_irq", timer_irq, 1'b0);
		report_test("reset and stretch");

		for (int i = 0; i < 16; i++) begin
			rng = next_random(rng);
			data = rng;
			rng = next_random(rng);
			gpio_write(data, rng[3:0]);
			bus_xfer(gpio_addr, 4'h0, '0, 1'b1, gpio_m, rd);
		end
		report_test("gpio byte writes");

		// low byte all ones starts the scroll
		for (int i = 0; i < 3; i++) begin
			rng = next_random(rng);
			gpio_write(rng | 32'hff, 4'hf);
			leds_settle();
			check_value("leds", leds, gpio_m[7:0] >> shift_m);
		end
		// shift is retained
		gpio_write(32'h0000_005a, 4'h1);
		leds_settle();
		check_value("leds", leds, gpio_m[7:0] >> shift_m);
		report_test("led scrolling");

		rng = next_random(rng);
		data = 32'd8 + rng[4:0];
		bus_xfer(count_addr, 4'hf, data, 1'b1, '0, rd);
		bus_xfer(ctrl_addr, 4'hf, 32'h1, 1'b1, '0, rd);
		prev = data;
		polls = 0;
		do begin
			bus_xfer(count_addr, 4'h0, '0, 1'b0, '0, rd);
			assert (rd <= prev) else begin
				errors++;
				$display("[ERROR] timer count = %h, previous %h", rd, prev);
			end
			prev = rd;
			polls++;
		end while (rd != 0 && polls < 64);
		if (rd != 0)
			note_error("timer count did not reach zero in time");
		@(negedge clk);
		check_value("timer_irq", timer_irq, 1'b1);
		// pending and enable both set
		bus_xfer(ctrl_addr, 4'h0, '0, 1'b1, 32'h3, rd);
		irq_clear_req = 1'b1;
		bus_xfer(ctrl_addr, 4'h1, 32'h3, 1'b1, 32'h3, rd);
		irq_clear_req = 1'b0;
		@(negedge clk);
		check_value("timer_irq", timer_irq, 1'b0);
		bus_xfer(ctrl_addr, 4'h0, '0, 1'b1, 32'h1, rd);
		report_test("timer");

		// regions outside 03 and 04
		bus_xfer(32'h0500_0000, 4'h0, '0, 1'b1, '0, rd);
		bus_xfer(32'h0000_0010, 4'h0, '0, 1'b1, '0, rd);
		rng = next_random(rng);
		bus_xfer({8'h7f, rng[23:0]}, 4'hf, rng, 1'b1, '0, rd);
		bus_xfer(gpio_addr, 4'h0, '0, 1'b1, gpio_m, rd);
		bus_xfer(count_addr, 4'h0, '0, 1'b1, '0, rd);
		bus_xfer(ctrl_addr, 4'h0, '0, 1'b1, 32'h1, rd);
		report_test("unmapped address");

		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
hdl/iomem_pkg.sv
hdl/por_stretch.sv
hdl/iomem_decode.sv
hdl/gpio_reg.sv
hdl/led_scroller.sv
hdl/iomem_timer.sv
hdl/board_top.sv
verification/tb_board_top.sv
